// File: design/stm_pkg.sv
package stm_pkg;

  // point index and divider widths follow the register map.
  localparam int idx_w = 16;
  localparam int div_w = 16;

  // repeat count and loop counter width.
  localparam int rep_w = 32;

  // all ones in a repeat field means the segment loops forever.
  localparam logic [rep_w-1:0] rep_infinite = '1;

  // settings of one segment's index timer, 32 bits.
  typedef struct packed {
    logic [idx_w-1:0] cycle;     // number of points, at least 1.
    logic [div_w-1:0] freq_div;  // clocks per point minus one.
  } timer_cfg_t;

  // swap request, 65 bits.
  typedef struct packed {
    logic                  req_segment;  // segment to play next.
    logic [1:0][rep_w-1:0] rep;          // repeat count per segment.
  } swap_cfg_t;

  // everything the host writes in one update, 129 bits.
  typedef struct packed {
    timer_cfg_t [1:0] timer;  // index 0 is segment 0.
    swap_cfg_t        swap;
  } stm_cfg_t;

endpackage

// File: design/stm_index_timer.sv
`timescale 1ns/100ps

module stm_index_timer (
  input  logic                      CLK,
  input  logic                      rst_n,
  input  logic                      update,
  input  stm_pkg::timer_cfg_t       cfg,
  output logic [stm_pkg::idx_w-1:0] idx
);

  import stm_pkg::*;

  timer_cfg_t       cfg_r;
  logic [div_w-1:0] div_cnt;
  logic [idx_w-1:0] last_idx;
  logic [idx_w-1:0] idx_next;
  logic             tick;

  assign last_idx = cfg_r.cycle - 1'b1;

  // also catches a divider left above a shrunken freq_div.
  assign tick = (div_cnt >= cfg_r.freq_div);

  // wrap also covers an index beyond a shortened cycle.
  always_comb begin
    if (idx >= last_idx) begin
      idx_next = '0;
    end else begin
      idx_next = idx + 1'b1;
    end
  end

  // settings register, loaded on the update strobe.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      cfg_r.cycle    <= idx_w'(1);
      cfg_r.freq_div <= '0;
    end else if (update) begin
      cfg_r <= cfg;
    end
  end

  // rate divider keeps running through updates.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // point index steps once per divider period.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      idx <= '0;
    end else if (tick) begin
      idx <= idx_next;
    end
  end

endmodule

// File: design/stm_swapchain.sv
`timescale 1ns/100ps

module stm_swapchain (
  input  logic                      CLK,
  input  logic                      rst_n,
  input  logic                      update,
  input  stm_pkg::swap_cfg_t        cfg,
  input  logic [stm_pkg::idx_w-1:0] idx0,
  input  logic [stm_pkg::idx_w-1:0] idx1,
  output logic                      segment,
  output logic                      stop,
  output logic [stm_pkg::idx_w-1:0] idx_out
);

  import stm_pkg::*;

  typedef enum logic [1:0] {
    WAIT_START,
    FINITE_LOOP,
    INFINITE_LOOP
  } state_t;

  state_t           state;
  logic             req_seg_r;
  logic [rep_w-1:0] rep_r;
  logic [rep_w-1:0] loop_cnt;
  logic [idx_w-1:0] idx0_prev;
  logic [idx_w-1:0] idx1_prev;

  logic [rep_w-1:0] req_rep;
  logic             req_rep_inf;
  logic             swap_req;
  logic             start_finite;
  logic             req_at_zero;
  logic             wrap0;
  logic             wrap1;
  logic             play_wrap;
  logic             seg_next;

  assign req_rep     = cfg.rep[cfg.req_segment];  // rep of the segment asked for.
  assign req_rep_inf = (req_rep == rep_infinite);

  assign swap_req     = update && (cfg.req_segment != segment);
  assign start_finite = swap_req && !req_rep_inf;

  // the requested segment may start only at its first point.
  assign req_at_zero = req_seg_r ? (idx1 == '0) : (idx0 == '0);

  assign wrap0     = (idx0 != idx0_prev) && (idx0 == '0);  // just back at zero.
  assign wrap1     = (idx1 != idx1_prev) && (idx1 == '0);
  assign play_wrap = segment ? wrap1 : wrap0;  // one pass done.

  always_comb begin  // segment taken at the coming edge.
    seg_next = segment;
    if (update) begin
      if (swap_req && req_rep_inf) begin
        seg_next = cfg.req_segment;
      end
    end else if (state == WAIT_START && req_at_zero) begin
      seg_next = req_seg_r;
    end
  end

  always_ff @(posedge CLK) begin  // pending finite request.
    if (start_finite) begin
      req_seg_r <= cfg.req_segment;
      rep_r     <= req_rep;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state    <= INFINITE_LOOP;
      stop     <= 1'b0;
      loop_cnt <= '0;
    end else if (update) begin
      if (start_finite) begin
        state <= WAIT_START;
      end else begin
        stop  <= 1'b0;  // same or new segment loops forever.
        state <= INFINITE_LOOP;
      end
    end else begin
      case (state)
        WAIT_START: begin
          if (req_at_zero) begin
            stop     <= 1'b0;
            loop_cnt <= '0;
            state    <= FINITE_LOOP;
          end
        end
        FINITE_LOOP: begin
          if (play_wrap) begin
            if (loop_cnt == rep_r) begin
              stop <= 1'b1;  // held until the next update.
            end else begin
              loop_cnt <= loop_cnt + 1'b1;
            end
          end
        end
        INFINITE_LOOP: begin
          state <= INFINITE_LOOP;
        end
        default: begin
          state <= INFINITE_LOOP;
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin  // index history for the wrap detect.
    if (!rst_n) begin
      idx0_prev <= '0;
      idx1_prev <= '0;
    end else begin
      idx0_prev <= idx0;
      idx1_prev <= idx1;
    end
  end

  always_ff @(posedge CLK) begin  // segment and its index move together.
    if (!rst_n) begin
      segment <= 1'b0;
      idx_out <= '0;
    end else begin
      segment <= seg_next;
      idx_out <= seg_next ? idx1 : idx0;
    end
  end

endmodule

// File: design/stm_top.sv
`timescale 1ns/100ps

module stm_top (
  input  logic                      CLK,
  input  logic                      rst_n,
  input  logic                      update,
  input  stm_pkg::stm_cfg_t         cfg,
  output logic                      segment,
  output logic                      stop,
  output logic [stm_pkg::idx_w-1:0] idx_out
);

  import stm_pkg::*;

  logic [idx_w-1:0] timer_idx0;
  logic [idx_w-1:0] timer_idx1;

  // segment 0 timer.
  stm_index_timer u_timer0 (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .update (update),
    .cfg    (cfg.timer[0]),
    .idx    (timer_idx0)
  );

  // segment 1 timer.
  stm_index_timer u_timer1 (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .update (update),
    .cfg    (cfg.timer[1]),
    .idx    (timer_idx1)
  );

  // picks the playing segment and its index.
  stm_swapchain u_swapchain (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .update  (update),
    .cfg     (cfg.swap),
    .idx0    (timer_idx0),
    .idx1    (timer_idx1),
    .segment (segment),
    .stop    (stop),
    .idx_out (idx_out)
  );

endmodule

// File: testbench/stm_checker.sv
`timescale 1ns/100ps

module stm_checker (
  input  logic                      CLK,
  input  logic                      rst_n,
  input  logic                      update,
  input  stm_pkg::stm_cfg_t         cfg,
  input  logic                      segment,
  input  logic                      stop,
  input  logic [stm_pkg::idx_w-1:0] idx_out,
  output int                        err_cnt
);

  import stm_pkg::*;

  typedef enum {mode_wait, mode_finite, mode_forever} mode_t;

  logic [idx_w-1:0] cyc   [2];  // timer model, one entry per segment.
  logic [15:0]      fdiv  [2];
  logic [15:0]      div   [2];
  logic [idx_w-1:0] idx   [2];
  logic [idx_w-1:0] prev  [2];

  mode_t            mode;  // swapchain model.
  logic             seg;
  logic             stop_m;
  logic [rep_w-1:0] loops;
  logic             pend_seg;
  logic [rep_w-1:0] pend_rep;
  logic [idx_w-1:0] out_m;
  bit               armed = 0;

  initial err_cnt = 0;

  // runs on the old timer indices, so it goes before step_timers.
  task automatic step_swap();
    logic [rep_w-1:0] want_rep;
    logic             wrapped;
    wrapped  = (idx[seg] == '0) && (prev[seg] != '0);
    want_rep = cfg.swap.rep[cfg.swap.req_segment];
    if (update) begin
      if (cfg.swap.req_segment == seg) begin
        stop_m = 1'b0;
        mode   = mode_forever;
      end else if (want_rep == rep_infinite) begin
        seg    = cfg.swap.req_segment;
        stop_m = 1'b0;
        mode   = mode_forever;
      end else begin
        pend_seg = cfg.swap.req_segment;
        pend_rep = want_rep;
        mode     = mode_wait;
      end
    end else if (mode == mode_wait) begin
      if (idx[pend_seg] == '0) begin  // start on the first point.
        seg    = pend_seg;
        loops  = '0;
        stop_m = 1'b0;
        mode   = mode_finite;
      end
    end else if (mode == mode_finite && wrapped) begin
      if (loops == pend_rep) stop_m = 1'b1;
      else loops = loops + 1;
    end
    out_m   = idx[seg];  // index of the segment now selected.
    prev[0] = idx[0];
    prev[1] = idx[1];
  endtask

  task automatic step_timers();
    for (int s = 0; s < 2; s++) begin
      if (div[s] >= fdiv[s]) begin
        div[s] = '0;
        if (int'(idx[s]) + 1 >= int'(cyc[s])) idx[s] = '0;
        else idx[s] = idx[s] + 1;
      end else begin
        div[s] = div[s] + 1;
      end
      if (update) begin  // new settings apply from the next edge.
        cyc[s]  = cfg.timer[s].cycle;
        fdiv[s] = cfg.timer[s].freq_div;
      end
    end
  endtask

  always @(posedge CLK) begin
    if (!rst_n) begin
      for (int s = 0; s < 2; s++) begin
        cyc[s]  = 1;
        fdiv[s] = '0;
        div[s]  = '0;
        idx[s]  = '0;
        prev[s] = '0;
      end
      mode     = mode_forever;
      seg      = 1'b0;
      stop_m   = 1'b0;
      loops    = '0;
      pend_seg = 1'b0;
      pend_rep = '0;
      out_m    = '0;
      armed    = 1;
    end else begin
      step_swap();
      step_timers();
    end
  end

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] expd);
    if (got !== expd) begin
      $display("FAIL at %0t: %s is %0d, model expects %0d", $time, name, got, expd);
      err_cnt++;
    end
  endtask

  always @(negedge CLK) begin  // outputs settle after the rising edge.
    if (armed) begin
      compare_field("segment", 32'(segment), 32'(seg));
      compare_field("stop", 32'(stop), 32'(stop_m));
      compare_field("idx_out", 32'(idx_out), 32'(out_m));
    end
  end

endmodule

// File: testbench/tb_stm.sv
`timescale 1ns/100ps

module tb_stm;

  import stm_pkg::*;

  logic             CLK;
  logic             rst_n;
  logic             update;
  stm_cfg_t         cfg;
  logic             segment;
  logic             stop;
  logic [idx_w-1:0] idx_out;

  int          model_errs;
  int          local_err;
  int          n_pass;
  int          n_fail;
  int          errs_before;
  logic [31:0] rng_state;
  logic [31:0] r;

  stm_top DUT (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .update  (update),
    .cfg     (cfg),
    .segment (segment),
    .stop    (stop),
    .idx_out (idx_out)
  );

  stm_checker u_checker (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .update  (update),
    .cfg     (cfg),
    .segment (segment),
    .stop    (stop),
    .idx_out (idx_out),
    .err_cnt (model_errs)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic stm_cfg_t make_cfg(input int cyc0, input int fd0, input int cyc1,
                                        input int fd1, input logic req,
                                        input logic [rep_w-1:0] rep0,
                                        input logic [rep_w-1:0] rep1);
    stm_cfg_t c;
    c.timer[0].cycle    = 16'(cyc0);
    c.timer[0].freq_div = 16'(fd0);
    c.timer[1].cycle    = 16'(cyc1);
    c.timer[1].freq_div = 16'(fd1);
    c.swap.req_segment  = req;
    c.swap.rep[0]       = rep0;
    c.swap.rep[1]       = rep1;
    return c;
  endfunction

  // small ranges so swaps and wraps happen often.
  function automatic stm_cfg_t random_cfg();
    stm_cfg_t    c;
    logic [31:0] v;
    for (int s = 0; s < 2; s++) begin
      v = next_rand();
      c.timer[s].cycle    = 16'(v[2:0] + 1);
      c.timer[s].freq_div = 16'(v[4:3]);
      c.swap.rep[s]       = (v[7:5] == 3'd7) ? rep_infinite : 32'(v[6:5]);
    end
    v = next_rand();
    c.swap.req_segment = v[8];
    return c;
  endfunction

  task automatic pulse_update(input stm_cfg_t c);
    @(negedge CLK);
    cfg    = c;
    update = 1'b1;
    @(negedge CLK);
    update = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge CLK);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expd);
    if (got !== expd) begin
      $display("FAIL at %0t: %s is %0d, expected %0d", $time, name, got, expd);
      local_err++;
    end
  endtask

  task automatic wait_segment(input logic want, input int limit);
    int n;
    n = 0;
    while (segment !== want && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (segment !== want) begin
      $display("timeout: segment did not switch to %0d within %0d cycles", want, limit);
      local_err++;
    end
  endtask

  task automatic wait_stop(input int limit);
    int n;
    n = 0;
    while (stop !== 1'b1 && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (stop !== 1'b1) begin
      $display("timeout: stop was not raised within %0d cycles", limit);
      local_err++;
    end
  endtask

  task automatic wait_index(input int want, input int limit);
    int n;
    n = 0;
    while (idx_out !== 16'(want) && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (idx_out !== 16'(want)) begin
      $display("timeout: index never reached %0d within %0d cycles", want, limit);
      local_err++;
    end
  endtask

  task automatic close_test(input string name);
    if (model_errs + local_err == errs_before) begin
      $display("test %s: passed", name);
      n_pass++;
    end else begin
      $display("test %s: failed", name);
      n_fail++;
    end
    errs_before = model_errs + local_err;
  endtask

  initial begin
    rst_n       = 1'b0;
    update      = 1'b0;
    cfg         = '0;
    rng_state   = 32'd54;
    local_err   = 0;
    n_pass      = 0;
    n_fail      = 0;
    errs_before = 0;
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;

    // reset values, then segment 0 stepping.
    check_value("segment", 32'(segment), 0);
    check_value("stop", 32'(stop), 0);
    check_value("idx_out", 32'(idx_out), 0);
    pulse_update(make_cfg(5, 2, 3, 1, 1'b0, rep_infinite, rep_infinite));
    wait_index(4, 2000);
    wait_index(0, 2000);
    close_test("reset and stepping");

    pulse_update(make_cfg(5, 2, 3, 1, 1'b1, rep_infinite, rep_infinite));
    check_value("segment", 32'(segment), 1);
    check_value("stop", 32'(stop), 0);
    idle_cycles(50);
    check_value("segment", 32'(segment), 1);
    check_value("stop", 32'(stop), 0);
    close_test("infinite swap");

    pulse_update(make_cfg(5, 2, 3, 1, 1'b0, 32'd2, rep_infinite));
    check_value("segment", 32'(segment), 1);  // still waiting for index zero.
    wait_segment(1'b0, 2000);
    wait_stop(2000);
    idle_cycles(30);
    check_value("stop", 32'(stop), 1);
    check_value("segment", 32'(segment), 0);
    close_test("finite swap and stop");

    pulse_update(make_cfg(5, 2, 3, 1, 1'b0, 32'd1, 32'd1));
    check_value("stop", 32'(stop), 0);
    idle_cycles(200);
    check_value("stop", 32'(stop), 0);
    check_value("segment", 32'(segment), 0);
    close_test("same segment update");

    // long cycle first, then a shrink mid-run.
    pulse_update(make_cfg(8, 0, 8, 1, 1'b0, rep_infinite, rep_infinite));
    idle_cycles(5);
    pulse_update(make_cfg(2, 0, 3, 1, 1'b0, rep_infinite, rep_infinite));
    for (int i = 0; i < 5000; i++) begin
      @(negedge CLK);
      r = next_rand();
      if (r[3:0] == 4'd0) begin
        cfg    = random_cfg();
        update = 1'b1;
      end else begin
        update = 1'b0;
      end
    end
    @(negedge CLK);
    update = 1'b0;
    idle_cycles(4);
    close_test("random reconfiguration");

    $display("%0d tests passed, %0d failed, %0d model mismatches, %0d other errors",
             n_pass, n_fail, model_errs, local_err);
    if (n_fail == 0 && model_errs == 0 && local_err == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
design/stm_pkg.sv
design/stm_index_timer.sv
design/stm_swapchain.sv
design/stm_top.sv
testbench/stm_checker.sv
testbench/tb_stm.sv
